// ==== source/decode_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode package for the out-of-order RV32IM decode stage
// Word and index types, opcode/unit/ALU encodings, operand selects
// and the write-back slot constants
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package decode_pkg;

  localparam int CB_INDEX_W = 6;

  typedef logic [31:0]           word_t;
  typedef logic [4:0]            reg_idx_t;
  typedef logic [CB_INDEX_W-1:0] cb_index_t;

  // Reduced RV32 major opcodes
  typedef enum logic [6:0] {
    OPC_LUI     = 7'b0110111,
    OPC_AUIPC   = 7'b0010111,
    OPC_OP_IMM  = 7'b0010011,
    OPC_OP      = 7'b0110011,
    OPC_LOAD    = 7'b0000011,
    OPC_STORE   = 7'b0100011,
    OPC_MISCMEM = 7'b0001111
  } rv_opcode_t;

  typedef enum logic [1:0] {
    FU_ARITH,
    FU_MUL,
    FU_DIV,
    FU_LS
  } fu_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC_A_RS1, SRC_A_IMM_S, SRC_A_PC, SRC_A_ZERO
  } src_a_sel_t;

  typedef enum logic [1:0] {
    SRC_B_RS2, SRC_B_IMM_I, SRC_B_SHAMT, SRC_B_IMM_U
  } src_b_sel_t;

  // Write-back port reservation, slot n frees after n cycles
  localparam int WB_SLOTS      = 18;
  localparam int ALU_WB_SLOT   = 0;
  localparam int MUL_WB_SLOT   = 3;
  localparam int DIV_WB_SLOT   = 17;
  localparam int DIV_FAST_SLOT = 0;

  // Signed overflow dividend, divider finishes early
  localparam word_t DIV_OVF_DIVIDEND = 32'h8000_0000;

endpackage

// ==== source/decode_ctrl_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder control interface
// Carries decoded fields from the instruction decoder to the operand,
// write-back tracking, dispatch and fence logic
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface decode_ctrl_if;

  decode_pkg::rv_opcode_t opcode;
  logic                   valid_op;
  decode_pkg::fu_t        fu;
  decode_pkg::alu_op_t    alu_op;
  logic [2:0]             funct3;
  decode_pkg::reg_idx_t   rs1, rs2, rd;
  logic [11:0]            imm_i, imm_s;
  decode_pkg::word_t      imm_u;
  logic [4:0]             shamt;
  decode_pkg::src_a_sel_t src_a_sel;
  decode_pkg::src_b_sel_t src_b_sel;
  logic                   ifence;

  modport decoder (
    output opcode, valid_op, fu, alu_op, funct3, rs1, rs2, rd,
           imm_i, imm_s, imm_u, shamt, src_a_sel, src_b_sel, ifence
  );

  modport operands (input imm_i, imm_s, imm_u, shamt, src_a_sel, src_b_sel);

  modport tracker (input opcode, valid_op, fu);

  modport dispatch (input opcode, valid_op, fu, alu_op, funct3, rd);

  modport fence (input ifence);

endinterface

// ==== source/instr_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Reduced RV32IM control unit: register fields, immediates, target
// unit, ALU operation and operand selects
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decoder (
  input decode_pkg::word_t instr,
  decode_ctrl_if.decoder   ctrl
);

  decode_pkg::rv_opcode_t opc;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic                   is_shift;

  assign opc    = decode_pkg::rv_opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // SLLI / SRLI / SRAI take the shift amount
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  // Raw fields
  assign ctrl.opcode = opc;
  assign ctrl.funct3 = funct3;
  assign ctrl.rs1    = instr[19:15];
  assign ctrl.rs2    = instr[24:20];
  assign ctrl.rd     = instr[11:7];
  assign ctrl.imm_i  = instr[31:20];
  assign ctrl.imm_s  = {instr[31:25], instr[11:7]};
  assign ctrl.imm_u  = {instr[31:12], 12'b0};
  assign ctrl.shamt  = instr[24:20];

  always_comb begin
    ctrl.valid_op  = 1'b1;
    ctrl.fu        = decode_pkg::FU_ARITH;
    ctrl.src_a_sel = decode_pkg::SRC_A_RS1;
    ctrl.src_b_sel = decode_pkg::SRC_B_RS2;
    ctrl.ifence    = 1'b0;
    case (opc)
      decode_pkg::OPC_LUI: begin
        ctrl.src_a_sel = decode_pkg::SRC_A_ZERO;
        ctrl.src_b_sel = decode_pkg::SRC_B_IMM_U;
      end
      decode_pkg::OPC_AUIPC: begin
        ctrl.src_a_sel = decode_pkg::SRC_A_PC;
        ctrl.src_b_sel = decode_pkg::SRC_B_IMM_U;
      end
      decode_pkg::OPC_OP_IMM: begin
        ctrl.src_b_sel = is_shift ? decode_pkg::SRC_B_SHAMT : decode_pkg::SRC_B_IMM_I;
      end
      decode_pkg::OPC_OP: begin
        // M extension, low funct3 is multiply
        if (funct7 == 7'b0000001) begin
          ctrl.fu = funct3[2] ? decode_pkg::FU_DIV : decode_pkg::FU_MUL;
        end
      end
      decode_pkg::OPC_LOAD: begin
        ctrl.fu        = decode_pkg::FU_LS;
        ctrl.src_b_sel = decode_pkg::SRC_B_IMM_I;
      end
      decode_pkg::OPC_STORE: begin
        ctrl.fu        = decode_pkg::FU_LS;
        ctrl.src_a_sel = decode_pkg::SRC_A_IMM_S;
      end
      decode_pkg::OPC_MISCMEM: begin
        ctrl.ifence = (funct3 == 3'b001);
      end
      default: ctrl.valid_op = 1'b0;
    endcase
  end

  // ALU operation, address and upper-immediate forms add
  always_comb begin
    ctrl.alu_op = decode_pkg::ADD;
    if ((opc == decode_pkg::OPC_OP) || (opc == decode_pkg::OPC_OP_IMM)) begin
      case (funct3)
        3'b000: ctrl.alu_op = ((opc == decode_pkg::OPC_OP) && instr[30]) ?
                              decode_pkg::SUB : decode_pkg::ADD;
        3'b001: ctrl.alu_op = decode_pkg::SLL;
        3'b010: ctrl.alu_op = decode_pkg::SLT;
        3'b011: ctrl.alu_op = decode_pkg::SLTU;
        3'b100: ctrl.alu_op = decode_pkg::XOR;
        3'b101: ctrl.alu_op = instr[30] ? decode_pkg::SRA : decode_pkg::SRL;
        3'b110: ctrl.alu_op = decode_pkg::OR;
        default: ctrl.alu_op = decode_pkg::AND;
      endcase
    end
  end

endmodule

// ==== source/operand_select.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand selection
// Sign-extends immediates, applies bypass data and muxes the two
// functional-unit operands and the store data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_select (
  decode_ctrl_if.operands   ctrl,
  input decode_pkg::word_t  pc,
  input decode_pkg::word_t  rs1_data,
  input decode_pkg::word_t  rs2_data,
  input decode_pkg::word_t  rs1_bypass_data,
  input decode_pkg::word_t  rs2_bypass_data,
  input logic               rs1_bypass_ena,
  input logic               rs2_bypass_ena,
  output decode_pkg::word_t port_a,
  output decode_pkg::word_t port_b,
  output decode_pkg::word_t store_data
);

  decode_pkg::word_t imm_i_ext, imm_s_ext;
  decode_pkg::word_t rs1_val, rs2_val;

  assign imm_i_ext = {{20{ctrl.imm_i[11]}}, ctrl.imm_i};
  assign imm_s_ext = {{20{ctrl.imm_s[11]}}, ctrl.imm_s};

  // Bypass wins over the register file
  assign rs1_val = rs1_bypass_ena ? rs1_bypass_data : rs1_data;
  assign rs2_val = rs2_bypass_ena ? rs2_bypass_data : rs2_data;

  assign store_data = rs2_val;

  always_comb begin
    case (ctrl.src_a_sel)
      decode_pkg::SRC_A_RS1:   port_a = rs1_val;
      decode_pkg::SRC_A_IMM_S: port_a = imm_s_ext;
      decode_pkg::SRC_A_PC:    port_a = pc;
      default:                 port_a = '0;
    endcase
  end

  // Stores carry the base register on port B
  always_comb begin
    case (ctrl.src_b_sel)
      decode_pkg::SRC_B_RS2:   port_b = (ctrl.src_a_sel == decode_pkg::SRC_A_IMM_S) ?
                                        rs1_val : rs2_val;
      decode_pkg::SRC_B_IMM_I: port_b = imm_i_ext;
      decode_pkg::SRC_B_SHAMT: port_b = {27'b0, ctrl.shamt};
      default:                 port_b = ctrl.imm_u;
    endcase
  end

  always_comb begin
    assert (!$isunknown({ctrl.src_a_sel, ctrl.src_b_sel}))
      else $error("operand select is unknown");
  end

endmodule

// ==== source/fence_tracker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fence.i tracker
// One cache flush pulse per fence.i and flush-completion flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fence_tracker (
  input  logic         CLK,
  input  logic         nRST,
  decode_ctrl_if.fence ctrl,
  input  logic         pc_en,
  input  logic         iflush_done,
  input  logic         dflush_done,
  output logic         icache_flush,
  output logic         dcache_flush,
  output logic         iflushed,
  output logic         dflushed
);

  logic ifence_reg;
  logic ifence_pulse;

  // Back-to-back fences act as one
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifence_reg <= 1'b0;
    end else if (pc_en) begin
      ifence_reg <= ctrl.ifence;
    end
  end

  assign ifence_pulse = ctrl.ifence && !ifence_reg && pc_en;
  assign icache_flush = ifence_pulse;
  assign dcache_flush = ifence_pulse;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else begin
      if (ifence_pulse) iflushed <= 1'b0;
      else if (iflush_done && pc_en) iflushed <= 1'b1;
      if (ifence_pulse) dflushed <= 1'b0;
      else if (dflush_done && pc_en) dflushed <= 1'b1;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) ifence_pulse |=> !ifence_pulse)
    else $error("flush pulse held for two cycles");

endmodule

// ==== source/wb_conflict_tracker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-back conflict tracker
// Shifting slot register that reserves the shared write-back port for
// ALU, multiply and divide results and flags collisions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_conflict_tracker (
  input  logic              CLK,
  input  logic              nRST,
  decode_ctrl_if.tracker    ctrl,
  input  logic              stall_fetch_decode,
  input  decode_pkg::word_t port_a,
  input  decode_pkg::word_t port_b,
  output logic              wb_conflict
);

  logic [decode_pkg::WB_SLOTS-1:0] slots, claim, next_slots;
  logic                            uses_wb;
  logic                            div_special;

  // Loads, stores and fences do not use this port
  assign uses_wb = ctrl.valid_op && (ctrl.opcode != decode_pkg::OPC_MISCMEM) &&
                   (ctrl.fu != decode_pkg::FU_LS);

  // Overflow and divide-by-zero/-1 cases finish right away
  assign div_special = (port_a == decode_pkg::DIV_OVF_DIVIDEND) ||
                       (port_b == '1) || (port_b == '0);

  always_comb begin
    claim = '0;
    if (uses_wb) begin
      case (ctrl.fu)
        decode_pkg::FU_DIV: begin
          if (div_special) claim[decode_pkg::DIV_FAST_SLOT] = 1'b1;
          else claim[decode_pkg::DIV_WB_SLOT] = 1'b1;
        end
        decode_pkg::FU_MUL: claim[decode_pkg::MUL_WB_SLOT] = 1'b1;
        default:            claim[decode_pkg::ALU_WB_SLOT] = 1'b1;
      endcase
    end
  end

  assign wb_conflict = |(slots & claim);
  assign next_slots  = stall_fetch_decode ? slots : (slots | claim);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      slots <= '0;
    end else begin
      slots <= next_slots >> 1;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    (ctrl.opcode inside {decode_pkg::OPC_LOAD, decode_pkg::OPC_STORE,
                         decode_pkg::OPC_MISCMEM}) |-> !wb_conflict)
    else $error("write-back conflict raised for a non-writing unit");

endmodule

// ==== source/dispatch_latch.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode/execute latch
// Registers the issue bundle, holds under unit stalls, bubbles on
// flush or decode stall, and requests completion-buffer entries
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dispatch_latch (
  input  logic                  CLK,
  input  logic                  nRST,
  decode_ctrl_if.dispatch       ctrl,
  input  logic                  stall_fetch_decode,
  input  logic                  flush,
  input  logic                  stall_au,
  input  logic                  stall_mu,
  input  logic                  stall_du,
  input  logic                  stall_ls,
  input  decode_pkg::cb_index_t cur_tail,
  input  decode_pkg::word_t     port_a_in,
  input  decode_pkg::word_t     port_b_in,
  input  decode_pkg::word_t     store_data_in,
  output logic                  alloc_ena,
  output logic                  au_valid,
  output logic                  mu_valid,
  output logic                  du_valid,
  output logic                  ls_valid,
  output decode_pkg::alu_op_t   issue_alu_op,
  output logic [2:0]            issue_funct3,
  output decode_pkg::reg_idx_t  issue_rd,
  output decode_pkg::cb_index_t issue_index,
  output decode_pkg::word_t     port_a,
  output decode_pkg::word_t     port_b,
  output decode_pkg::word_t     store_data
);

  logic hold, bubble, load, issue;

  assign hold   = stall_au || stall_mu || stall_du || stall_ls;
  assign bubble = !hold && (flush || stall_fetch_decode);
  assign load   = !hold && !bubble;

  // fence.i gets no completion-buffer entry
  assign issue     = ctrl.valid_op && (ctrl.opcode != decode_pkg::OPC_MISCMEM);
  assign alloc_ena = !stall_fetch_decode && issue;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {au_valid, mu_valid, du_valid, ls_valid} <= '0;
    end else if (bubble) begin
      {au_valid, mu_valid, du_valid, ls_valid} <= '0;
    end else if (load) begin
      au_valid <= issue && (ctrl.fu == decode_pkg::FU_ARITH);
      mu_valid <= issue && (ctrl.fu == decode_pkg::FU_MUL);
      du_valid <= issue && (ctrl.fu == decode_pkg::FU_DIV);
      ls_valid <= issue && (ctrl.fu == decode_pkg::FU_LS);
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (load) begin
      issue_alu_op <= ctrl.alu_op;
      issue_funct3 <= ctrl.funct3;
      issue_rd     <= ctrl.rd;
      issue_index  <= cur_tail;
      port_a       <= port_a_in;
      port_b       <= port_b_in;
      store_data   <= store_data_in;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({au_valid, mu_valid, du_valid, ls_valid}))
    else $error("more than one unit valid");

endmodule

// ==== source/ooo_decode_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Out-of-order decode stage, top level
// Decoder, operand select, fence and write-back tracking and the
// decode/execute latch behind plain ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ooo_decode_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  decode_pkg::word_t     instr,
  input  decode_pkg::word_t     pc,
  input  decode_pkg::word_t     rs1_data,
  input  decode_pkg::word_t     rs2_data,
  input  logic                  rs1_bypass_ena,
  input  logic                  rs2_bypass_ena,
  input  decode_pkg::word_t     rs1_bypass_data,
  input  decode_pkg::word_t     rs2_bypass_data,
  input  decode_pkg::cb_index_t cur_tail,
  input  logic                  stall_fetch_decode,
  input  logic                  flush,
  input  logic                  pc_en,
  input  logic                  stall_au,
  input  logic                  stall_mu,
  input  logic                  stall_du,
  input  logic                  stall_ls,
  input  logic                  iflush_done,
  input  logic                  dflush_done,
  output decode_pkg::reg_idx_t  rs1,
  output decode_pkg::reg_idx_t  rs2,
  output logic                  alloc_ena,
  output logic                  wb_conflict,
  output logic                  icache_flush,
  output logic                  dcache_flush,
  output logic                  iflushed,
  output logic                  dflushed,
  output logic                  au_valid,
  output logic                  mu_valid,
  output logic                  du_valid,
  output logic                  ls_valid,
  output decode_pkg::alu_op_t   issue_alu_op,
  output logic [2:0]            issue_funct3,
  output decode_pkg::reg_idx_t  issue_rd,
  output decode_pkg::cb_index_t issue_index,
  output decode_pkg::word_t     port_a,
  output decode_pkg::word_t     port_b,
  output decode_pkg::word_t     store_data
);

  decode_pkg::word_t sel_port_a, sel_port_b, sel_store_data;

  decode_ctrl_if ctrl_if ();

  // Register file read indices
  assign rs1 = ctrl_if.rs1;
  assign rs2 = ctrl_if.rs2;

  instr_decoder u_instr_decoder (.instr(instr), .ctrl(ctrl_if.decoder));

  operand_select u_operand_select (
    .ctrl(ctrl_if.operands), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_bypass_data(rs1_bypass_data), .rs2_bypass_data(rs2_bypass_data),
    .rs1_bypass_ena(rs1_bypass_ena), .rs2_bypass_ena(rs2_bypass_ena),
    .port_a(sel_port_a), .port_b(sel_port_b), .store_data(sel_store_data)
  );

  fence_tracker u_fence_tracker (
    .CLK(CLK), .nRST(nRST), .ctrl(ctrl_if.fence), .pc_en(pc_en),
    .iflush_done(iflush_done), .dflush_done(dflush_done),
    .icache_flush(icache_flush), .dcache_flush(dcache_flush),
    .iflushed(iflushed), .dflushed(dflushed)
  );

  wb_conflict_tracker u_wb_conflict_tracker (
    .CLK(CLK), .nRST(nRST), .ctrl(ctrl_if.tracker),
    .stall_fetch_decode(stall_fetch_decode),
    .port_a(sel_port_a), .port_b(sel_port_b), .wb_conflict(wb_conflict)
  );

  dispatch_latch u_dispatch_latch (
    .CLK(CLK), .nRST(nRST), .ctrl(ctrl_if.dispatch),
    .stall_fetch_decode(stall_fetch_decode), .flush(flush),
    .stall_au(stall_au), .stall_mu(stall_mu), .stall_du(stall_du), .stall_ls(stall_ls),
    .cur_tail(cur_tail), .port_a_in(sel_port_a), .port_b_in(sel_port_b),
    .store_data_in(sel_store_data), .alloc_ena(alloc_ena),
    .au_valid(au_valid), .mu_valid(mu_valid), .du_valid(du_valid), .ls_valid(ls_valid),
    .issue_alu_op(issue_alu_op), .issue_funct3(issue_funct3), .issue_rd(issue_rd),
    .issue_index(issue_index), .port_a(port_a), .port_b(port_b), .store_data(store_data)
  );

endmodule

// ==== testbench/ooo_decode_stage_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the out-of-order decode stage
// Reference model of the issue latch, slots and fence flags, checked
// by concurrent assertions on the falling edge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ooo_decode_stage_tb;

  localparam int MAX_CYCLES = 600;

  logic        CLK, nRST;
  logic [31:0] instr, pc, rs1_data, rs2_data, rs1_bypass_data, rs2_bypass_data;
  logic        rs1_bypass_ena, rs2_bypass_ena;
  logic [5:0]  cur_tail;
  logic        stall_fetch_decode, flush, pc_en;
  logic        stall_au, stall_mu, stall_du, stall_ls;
  logic        iflush_done, dflush_done;

  logic [4:0]  rs1, rs2, issue_rd;
  logic        alloc_ena, wb_conflict, icache_flush, dcache_flush, iflushed, dflushed;
  logic        au_valid, mu_valid, du_valid, ls_valid;
  decode_pkg::alu_op_t issue_alu_op;
  logic [2:0]  issue_funct3;
  logic [5:0]  issue_index;
  logic [31:0] port_a, port_b, store_data;

  string       test_name = "reset";
  int          errors = 0;
  int          misses = 0;
  int          cycles = 0;
  int          conflict_seen = 0;
  int          pulse_seen = 0;
  logic [31:0] seed = 32'd82;

  // Expected decode of the instruction in decode
  logic        e_valid_op, e_fence, e_issue, e_alloc, e_pulse, e_conflict;
  logic [1:0]  e_fu;
  logic [3:0]  e_alu;
  logic [31:0] e_pa, e_pb, e_sd;
  logic [17:0] e_claim;

  // Model state
  logic [3:0]  m_valid;
  logic [3:0]  m_alu;
  logic [2:0]  m_funct3;
  logic [4:0]  m_rd;
  logic [5:0]  m_index;
  logic [31:0] m_pa, m_pb, m_sd;
  logic [17:0] m_slots;
  logic        m_ifence, m_iflushed, m_dflushed;

  ooo_decode_stage u_ooo_decode_stage (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] s1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, s1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] s2,
                                        input logic [4:0] s1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, s2, s1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] s2,
                                        input logic [4:0] s1);
    return {imm[11:5], s2, s1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [3:0] alu_for(input logic [2:0] f3, input logic is_reg,
                                         input logic b30);
    case (f3)
      3'd0: return (is_reg && b30) ? decode_pkg::SUB : decode_pkg::ADD;
      3'd1: return decode_pkg::SLL;
      3'd2: return decode_pkg::SLT;
      3'd3: return decode_pkg::SLTU;
      3'd4: return decode_pkg::XOR;
      3'd5: return b30 ? decode_pkg::SRA : decode_pkg::SRL;
      3'd6: return decode_pkg::OR;
      default: return decode_pkg::AND;
    endcase
  endfunction

  always_comb begin
    logic [31:0] r1, r2, imm_i, imm_s;
    logic        div_fast;
    r1 = rs1_bypass_ena ? rs1_bypass_data : rs1_data;
    r2 = rs2_bypass_ena ? rs2_bypass_data : rs2_data;
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    e_valid_op = 1'b1;
    e_fence = 1'b0;
    e_fu = decode_pkg::FU_ARITH;
    e_alu = decode_pkg::ADD;
    e_pa = r1;
    e_pb = r2;
    e_sd = r2;
    case (instr[6:0])
      7'b0110111: begin
        e_pa = '0;
        e_pb = {instr[31:12], 12'b0};
      end
      7'b0010111: begin
        e_pa = pc;
        e_pb = {instr[31:12], 12'b0};
      end
      7'b0010011: begin
        e_alu = alu_for(instr[14:12], 1'b0, instr[30]);
        e_pb = (instr[13:12] == 2'b01) ? {27'b0, instr[24:20]} : imm_i;
      end
      7'b0110011: begin
        e_alu = alu_for(instr[14:12], 1'b1, instr[30]);
        if (instr[31:25] == 7'b0000001)
          e_fu = instr[14] ? decode_pkg::FU_DIV : decode_pkg::FU_MUL;
      end
      7'b0000011: begin
        e_fu = decode_pkg::FU_LS;
        e_pb = imm_i;
      end
      7'b0100011: begin
        e_fu = decode_pkg::FU_LS;
        e_pa = imm_s;
        e_pb = r1;
      end
      7'b0001111: e_fence = (instr[14:12] == 3'b001);
      default: e_valid_op = 1'b0;
    endcase
    e_issue = e_valid_op && (instr[6:0] != 7'b0001111);
    e_alloc = e_issue && !stall_fetch_decode;
    e_pulse = e_fence && !m_ifence && pc_en;
    // Divide corner cases retire at once
    div_fast = (e_pa == 32'h8000_0000) || (e_pb == '1) || (e_pb == '0);
    e_claim = '0;
    if (e_issue && e_fu != decode_pkg::FU_LS) begin
      if (e_fu == decode_pkg::FU_MUL) e_claim[3] = 1'b1;
      else if (e_fu == decode_pkg::FU_DIV && !div_fast) e_claim[17] = 1'b1;
      else e_claim[0] = 1'b1;
    end
    e_conflict = |(m_slots & e_claim);
  end

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      m_valid    <= '0;
      m_slots    <= '0;
      m_ifence   <= 1'b0;
      m_iflushed <= 1'b1;
      m_dflushed <= 1'b1;
    end else begin
      if (!(stall_au || stall_mu || stall_du || stall_ls)) begin
        if (flush || stall_fetch_decode) begin
          m_valid <= '0;
        end else begin
          m_valid  <= e_issue ? (4'b1000 >> e_fu) : 4'b0000;
          m_alu    <= e_alu;
          m_funct3 <= instr[14:12];
          m_rd     <= instr[11:7];
          m_index  <= cur_tail;
          m_pa     <= e_pa;
          m_pb     <= e_pb;
          m_sd     <= e_sd;
        end
      end
      m_slots <= (stall_fetch_decode ? m_slots : (m_slots | e_claim)) >> 1;
      if (pc_en) m_ifence <= e_fence;
      if (e_pulse) m_iflushed <= 1'b0;
      else if (iflush_done && pc_en) m_iflushed <= 1'b1;
      if (e_pulse) m_dflushed <= 1'b0;
      else if (dflush_done && pc_en) m_dflushed <= 1'b1;
    end
  end

  // Conflicts and flush pulses seen on the DUT outputs
  always @(negedge CLK) begin
    if (nRST) begin
      if (wb_conflict) conflict_seen++;
      if (icache_flush) pulse_seen++;
    end
  end

  // Inputs settle 0.5 ns after the rising edge, so the falling edge is quiet
  assert property (@(negedge CLK) disable iff (!nRST)
    {au_valid, mu_valid, du_valid, ls_valid} == m_valid)
    else begin
      errors++;
      $display("error %s: valids expected %b actual %b", test_name, m_valid,
               {au_valid, mu_valid, du_valid, ls_valid});
    end

  assert property (@(negedge CLK) disable iff (!nRST)
    (m_valid == 0) || ({issue_index, port_a, port_b, store_data} == {m_index, m_pa, m_pb, m_sd}))
    else begin
      errors++;
      $display("error %s: index/a/b/store expected %h %h %h %h actual %h %h %h %h", test_name,
               m_index, m_pa, m_pb, m_sd, issue_index, port_a, port_b, store_data);
    end

  assert property (@(negedge CLK) disable iff (!nRST)
    (m_valid == 0) || ({issue_funct3, issue_rd} == {m_funct3, m_rd}))
    else begin
      errors++;
      $display("error %s: funct3/rd expected %h %h actual %h %h", test_name,
               m_funct3, m_rd, issue_funct3, issue_rd);
    end

  assert property (@(negedge CLK) disable iff (!nRST) !m_valid[3] || issue_alu_op == m_alu)
    else begin
      errors++;
      $display("error %s: alu_op expected %0d actual %0d", test_name, m_alu, issue_alu_op);
    end

  assert property (@(negedge CLK) disable iff (!nRST)
    {alloc_ena, wb_conflict, rs1, rs2} == {e_alloc, e_conflict, instr[19:15], instr[24:20]})
    else begin
      errors++;
      $display("error %s: alloc/conflict/rs1/rs2 expected %b %b %h %h actual %b %b %h %h",
               test_name, e_alloc, e_conflict, instr[19:15], instr[24:20],
               alloc_ena, wb_conflict, rs1, rs2);
    end

  assert property (@(negedge CLK) disable iff (!nRST)
    {icache_flush, dcache_flush, iflushed, dflushed} == {e_pulse, e_pulse, m_iflushed, m_dflushed})
    else begin
      errors++;
      $display("error %s: flush/flushed expected %b actual %b", test_name,
               {e_pulse, e_pulse, m_iflushed, m_dflushed},
               {icache_flush, dcache_flush, iflushed, dflushed});
    end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge CLK);
    #0.5;
  endtask

  task automatic random_regs();
    rs1_data = lcg_next();
    rs2_data = lcg_next();
    pc = lcg_next();
    cur_tail = 6'(lcg_next() >> 26);
  endtask

  initial begin
    logic [31:0] r;
    instr = 32'h0000_0013;
    pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    rs1_bypass_data = '0;
    rs2_bypass_data = '0;
    rs1_bypass_ena = 1'b0;
    rs2_bypass_ena = 1'b0;
    cur_tail = '0;
    stall_fetch_decode = 1'b0;
    flush = 1'b0;
    pc_en = 1'b1;
    {stall_au, stall_mu, stall_du, stall_ls} = '0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    nRST = 1'b0;
    repeat (16) @(posedge CLK);
    #0.5;
    nRST = 1'b1;

    test_name = "operands";
    for (int i = 0; i < 42; i++) begin
      r = lcg_next();
      random_regs();
      case (i % 7)
        0: instr = enc_i(r[31:20], r[19:15], 3'b000, r[11:7], 7'b0010011);
        1: instr = enc_i({7'b0100000, r[24:20]}, r[19:15], 3'b101, r[11:7], 7'b0010011);
        2: instr = {r[31:12], r[11:7], 7'b0110111};
        3: instr = {r[31:12], r[11:7], 7'b0010111};
        4: instr = enc_r(r[0] ? 7'b0000001 : {1'b0, r[1], 5'b0}, r[24:20], r[19:15],
                         r[14:12], r[11:7]);
        5: instr = enc_i(r[31:20], r[19:15], 3'b010, r[11:7], 7'b0000011);
        default: instr = enc_s(r[31:20], r[24:20], r[19:15]);
      endcase
      next_cycle();
    end

    test_name = "bypass";
    for (int i = 0; i < 12; i++) begin
      r = lcg_next();
      random_regs();
      rs1_bypass_data = lcg_next();
      rs2_bypass_data = lcg_next();
      rs1_bypass_ena = r[0];
      rs2_bypass_ena = r[1];
      instr = r[2] ? enc_s(r[31:20], r[24:20], r[19:15]) :
                     enc_r(7'b0000000, r[24:20], r[19:15], r[14:12], r[11:7]);
      next_cycle();
    end
    rs1_bypass_ena = 1'b0;
    rs2_bypass_ena = 1'b0;

    test_name = "backpressure";
    instr = enc_i(12'h123, 5'd1, 3'b000, 5'd2, 7'b0010011);
    next_cycle();
    stall_au = 1'b1;
    for (int i = 0; i < 3; i++) begin
      random_regs();
      instr = enc_i(12'(lcg_next() >> 20), 5'd3, 3'b010, 5'd4, 7'b0000011);
      next_cycle();
    end
    // Unit stall wins over decode stall
    stall_au = 1'b0;
    stall_mu = 1'b1;
    stall_fetch_decode = 1'b1;
    next_cycle();
    stall_mu = 1'b0;
    next_cycle();
    stall_fetch_decode = 1'b0;
    next_cycle();
    // Flush on its own
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    instr = enc_r(7'b0000001, 5'd5, 5'd6, 3'b000, 5'd7);
    next_cycle();
    stall_ls = 1'b1;
    next_cycle();
    stall_ls = 1'b0;
    next_cycle();

    test_name = "fence";
    instr = enc_i(12'h000, 5'd0, 3'b001, 5'd0, 7'b0001111);
    repeat (2) next_cycle();
    instr = 32'h0000_0013;
    next_cycle();
    iflush_done = 1'b1;
    pc_en = 1'b0;
    next_cycle();
    pc_en = 1'b1;
    next_cycle();
    iflush_done = 1'b0;
    dflush_done = 1'b1;
    next_cycle();
    dflush_done = 1'b0;
    repeat (2) next_cycle();

    test_name = "wb_conflict";
    instr = enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3);
    next_cycle();
    instr = enc_i(12'h010, 5'd1, 3'b010, 5'd4, 7'b0000011);
    repeat (2) next_cycle();
    instr = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5);
    next_cycle();
    rs1_data = 32'd100;
    rs2_data = 32'd0;
    instr = enc_r(7'b0000001, 5'd2, 5'd1, 3'b100, 5'd6);
    next_cycle();
    rs2_data = 32'd7;
    next_cycle();
    next_cycle();
    // First ALU op lands just before the divide results
    instr = enc_i(12'h020, 5'd1, 3'b010, 5'd4, 7'b0000011);
    repeat (14) next_cycle();
    instr = enc_r(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd8);
    repeat (2) next_cycle();
    instr = 32'h0000_0013;
    repeat (3) next_cycle();

    if (conflict_seen == 0) begin
      misses++;
      $display("No write-back conflict was ever produced");
    end
    if (pulse_seen != 1) begin
      misses++;
      $display("Fence produced %0d flush pulses instead of one", pulse_seen);
    end
    $display("Value errors: %0d, scenario failures: %0d, cycles: %0d", errors, misses, cycles);
    if (errors == 0 && misses == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== ooo_decode.f ====
source/decode_pkg.sv
source/decode_ctrl_if.sv
source/instr_decoder.sv
source/operand_select.sv
source/fence_tracker.sv
source/wb_conflict_tracker.sv
source/dispatch_latch.sv
source/ooo_decode_stage.sv
testbench/ooo_decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ooo_decode_stage_tb \
  -f ooo_decode.f

./obj_dir/Vooo_decode_stage_tb | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1
